// ==== hw/mips_pkg.sv ====
package mips_pkg;

	//////////////////////////////
	// Widths
	localparam int WORD_W    = 32;
	localparam int ADDR_W    = 10;
	localparam int REG_IDX_W = 5;
	localparam int NUM_REGS  = 2 ** REG_IDX_W;
	localparam int MEM_WORDS = 1024;

	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [ADDR_W-1:0]    addr_t;    // Word address without byte lanes
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	//////////////////////////////
	// Opcodes
	localparam logic [5:0] OPC_RTYPE = 6'b000000;
	localparam logic [5:0] OPC_J     = 6'b000010;
	localparam logic [5:0] OPC_BEQ   = 6'b000100;
	localparam logic [5:0] OPC_BNE   = 6'b000101;
	localparam logic [5:0] OPC_ADDI  = 6'b001000;
	localparam logic [5:0] OPC_SLTI  = 6'b001010;
	localparam logic [5:0] OPC_ANDI  = 6'b001100;
	localparam logic [5:0] OPC_ORI   = 6'b001101;
	localparam logic [5:0] OPC_XORI  = 6'b001110;
	localparam logic [5:0] OPC_LUI   = 6'b001111;
	localparam logic [5:0] OPC_LW    = 6'b100011;
	localparam logic [5:0] OPC_SW    = 6'b101011;
	localparam logic [5:0] OPC_HALT  = 6'b111111;

	localparam logic [5:0] FN_JR     = 6'b001000;

	// Operation codes of the execute bus
	typedef enum logic [3:0] {
		ALU_SLL  = 4'd0,
		ALU_SRL  = 4'd1,
		ALU_SRA  = 4'd2,
		ALU_ADD  = 4'd3,
		ALU_AND  = 4'd4,
		ALU_OR   = 4'd5,
		ALU_XOR  = 4'd6,
		ALU_NOR  = 4'd7,
		ALU_SUB  = 4'd8,
		ALU_SLT  = 4'd9,
		ALU_LUI  = 4'd10,
		ALU_NONE = 4'd15
	} alu_op_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DECODE,
		ST_EXEC,
		ST_MEM,
		ST_WB,
		ST_HALT
	} ctrl_state_t;

endpackage

// ==== hw/decoder.sv ====
module decoder import mips_pkg::*;
(
	input  logic [5:0] opcode,
	input  logic [5:0] funct,
	output alu_op_t    alu_op,
	output logic       alu_src,    // Immediate as operand b
	output logic       reg_dst,    // 1 selects rd, 0 selects rt
	output logic       shamt_sel,  // Shift by instruction field
	output logic       mem_read,
	output logic       mem_write,
	output logic       branch,
	output logic       mem_to_reg,
	output logic       reg_write,
	output logic       is_jump,
	output logic       is_jr,
	output logic       is_halt
);

	always_comb
	begin
		alu_op     = ALU_NONE;
		alu_src    = 1'b0;
		reg_dst    = 1'b0;
		shamt_sel  = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		branch     = 1'b0;
		mem_to_reg = 1'b0;
		is_jump    = 1'b0;
		is_jr      = 1'b0;
		is_halt    = 1'b0;

		case (opcode)
			OPC_RTYPE:
			begin
				reg_dst = 1'b1;
				case (funct)
					6'b000000: alu_op = ALU_SLL;
					6'b000010: alu_op = ALU_SRL;
					6'b000011: alu_op = ALU_SRA;
					6'b000100: alu_op = ALU_SLL;  // sllv
					6'b000110: alu_op = ALU_SRL;  // srlv
					6'b000111: alu_op = ALU_SRA;  // srav
					6'b100000,
					6'b100001: alu_op = ALU_ADD;
					6'b100011: alu_op = ALU_SUB;  // subu
					6'b100100: alu_op = ALU_AND;
					6'b100101: alu_op = ALU_OR;
					6'b100110: alu_op = ALU_XOR;
					6'b100111: alu_op = ALU_NOR;
					6'b101010: alu_op = ALU_SLT;
					FN_JR:     is_jr  = 1'b1;
					default:   alu_op = ALU_NONE;
				endcase
				// Fixed shifts take the shamt field
				shamt_sel = (funct[5:2] == 4'b0000);
			end

			OPC_ADDI, OPC_SLTI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI:
			begin
				alu_src = 1'b1;  // rt destination by default
				case (opcode)
					OPC_ADDI: alu_op = ALU_ADD;
					OPC_SLTI: alu_op = ALU_SLT;
					OPC_ANDI: alu_op = ALU_AND;
					OPC_ORI:  alu_op = ALU_OR;
					OPC_XORI: alu_op = ALU_XOR;
					default:  alu_op = ALU_LUI;
				endcase
			end

			OPC_LW:
			begin
				alu_op     = ALU_ADD;  // base + offset
				alu_src    = 1'b1;
				mem_read   = 1'b1;
				mem_to_reg = 1'b1;
			end

			OPC_SW:
			begin
				alu_op    = ALU_ADD;
				alu_src   = 1'b1;
				mem_write = 1'b1;
			end

			OPC_BEQ, OPC_BNE:
			begin
				alu_op = ALU_SUB;  // Compare through zero flag
				branch = 1'b1;
			end

			OPC_J:    is_jump = 1'b1;
			OPC_HALT: is_halt = 1'b1;
			default:  alu_op  = ALU_NONE;
		endcase

		// No result means no write back, jr included
		reg_write = (alu_op != ALU_NONE) && !mem_write && !branch;
	end

	rw_excl: assert final (!(mem_read && mem_write))
		else $error("decoder: load and store both set for opcode %b", opcode);

endmodule

// ==== hw/alu.sv ====
module alu import mips_pkg::*;
(
	input  word_t          a,
	input  word_t          b,
	input  logic [4:0]     shamt,
	input  alu_op_t        op,
	output word_t          y,
	output logic           zero
);

	always_comb
	begin
		case (op)
			// Shifts act on b, the rt operand
			ALU_SLL: y = b << shamt;
			ALU_SRL: y = b >> shamt;
			ALU_SRA: y = word_t'($signed(b) >>> shamt);
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_NOR: y = ~(a | b);
			ALU_SLT: y = word_t'($signed(a) < $signed(b));
			ALU_LUI: y = {b[15:0], 16'h0000};
			default: y = '0;
		endcase
	end

	assign zero = (y == '0);  // beq/bne test

endmodule

// ==== hw/reg_file.sv ====
module reg_file import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t ra1,
	input  reg_idx_t ra2,
	input  logic     we,
	input  reg_idx_t wa,
	input  word_t    wd,
	output word_t    rd1,
	output word_t    rd2
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (we && wa != '0)  // $zero is never written
			regs[wa] <= wd;
	end

	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

endmodule

// ==== hw/core_ctrl.sv ====
module core_ctrl import mips_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       run,
	output logic       halted,
	// Memory requester
	output logic       req_valid,
	input  logic       req_ready,
	output logic       req_we,
	output addr_t      req_addr,
	output word_t      req_wdata,
	input  word_t      rdata,
	input  logic       rdata_valid,
	// Decoder
	output logic [5:0] opcode,
	output logic [5:0] funct,
	input  alu_op_t    alu_op,
	input  logic       alu_src,
	input  logic       reg_dst,
	input  logic       shamt_sel,
	input  logic       mem_read,
	input  logic       mem_write,
	input  logic       branch,
	input  logic       mem_to_reg,
	input  logic       reg_write,
	input  logic       is_jump,
	input  logic       is_jr,
	input  logic       is_halt,
	// Register file
	output reg_idx_t   ra1,
	output reg_idx_t   ra2,
	input  word_t      rd1,
	input  word_t      rd2,
	output logic       we,
	output reg_idx_t   wa,
	output word_t      wd,
	// ALU
	output word_t      alu_a,
	output word_t      alu_b,
	output logic [4:0] alu_shamt,
	input  word_t      alu_y,
	input  logic       alu_zero
);

	ctrl_state_t state;
	addr_t       pc;
	addr_t       next_pc;
	word_t       ir;
	word_t       res;        // ALU result
	word_t       mdr;        // Load data
	word_t       imm;
	logic        req_done;   // Accepted, waiting for data
	logic        zext;
	logic        mem_done;

	//////////////////////////////
	// Datapath

	assign opcode = ir[31:26];
	assign funct  = ir[5:0];
	assign ra1    = ir[25:21];  // rs
	assign ra2    = ir[20:16];  // rt

	// Logical immediates are zero extended
	assign zext = (alu_op == ALU_AND) || (alu_op == ALU_OR) || (alu_op == ALU_XOR);
	assign imm  = zext ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};

	assign alu_a     = rd1;
	assign alu_b     = alu_src ? imm : rd2;
	assign alu_shamt = shamt_sel ? ir[10:6] : rd1[4:0];

	assign we = (state == ST_WB) && reg_write;
	assign wa = reg_dst ? ir[15:11] : ir[20:16];
	assign wd = mem_to_reg ? mdr : res;

	assign req_valid = ((state == ST_FETCH) || (state == ST_MEM)) && !req_done;
	assign req_we    = (state == ST_MEM) && mem_write;
	assign req_addr  = (state == ST_MEM) ? addr_t'(res) : pc;
	assign req_wdata = rd2;  // Store data is rt

	assign halted = (state == ST_HALT);

	// Store ends on acceptance, load on returned data
	assign mem_done = mem_write ? (req_valid && req_ready) : rdata_valid;

	// pc already points past the branch here
	always_comb
	begin
		next_pc = pc;
		if (is_jump)
			next_pc = addr_t'(ir[25:0]);
		else if (is_jr)
			next_pc = addr_t'(rd1);
		else if (branch && (ir[26] ? !alu_zero : alu_zero))  // bit 26 marks bne
			next_pc = pc + addr_t'(imm);
	end

	//////////////////////////////
	// Sequencer

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= ST_IDLE;
			pc       <= '0;
			req_done <= 1'b0;
		end
		else
		begin
			if (req_valid && req_ready)
				req_done <= 1'b1;
			case (state)
				ST_IDLE:
				begin
					if (run)
					begin
						pc    <= '0;
						state <= ST_FETCH;
					end
				end
				ST_FETCH:
				begin
					if (rdata_valid)
					begin
						req_done <= 1'b0;
						pc       <= pc + 1'b1;
						state    <= ST_DECODE;
					end
				end
				ST_DECODE: state <= is_halt ? ST_HALT : ST_EXEC;
				ST_EXEC:
				begin
					pc <= next_pc;
					if (mem_read || mem_write)
						state <= ST_MEM;
					else if (reg_write)
						state <= ST_WB;
					else
						state <= ST_FETCH;
				end
				ST_MEM:
				begin
					if (mem_done)
					begin
						req_done <= 1'b0;
						state    <= reg_write ? ST_WB : ST_FETCH;
					end
				end
				ST_WB:   state <= ST_FETCH;
				default: state <= ST_HALT;  // Stays until reset
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == ST_FETCH && rdata_valid)
			ir <= rdata;
		if (state == ST_EXEC)
			res <= alu_y;
		if (state == ST_MEM && rdata_valid)
			mdr <= rdata;
	end

	req_hold: assert property (@(posedge clk) disable iff (rst)
		req_valid && !req_ready |=>
			req_valid && $stable(req_addr) && $stable(req_we) && $stable(req_wdata))
		else $error("core_ctrl: request dropped or changed before acceptance");

endmodule

// ==== hw/mem_arbiter.sv ====
module mem_arbiter import mips_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	// Core side
	input  logic  core_req_valid,
	output logic  core_req_ready,
	input  logic  core_req_we,
	input  addr_t core_req_addr,
	input  word_t core_req_wdata,
	output logic  core_rdata_valid,
	// Host side
	input  logic  host_req_valid,
	output logic  host_req_ready,
	input  logic  host_req_we,
	input  addr_t host_req_addr,
	input  word_t host_req_wdata,
	output logic  host_rdata_valid,
	// Memory port
	output logic  mem_en,
	output logic  mem_we,
	output addr_t mem_addr,
	output word_t mem_wdata
);

	logic last_host;  // Host won the last transfer

	// A lone requester wins at once and a contest goes to the other side
	assign host_req_ready = host_req_valid && (!core_req_valid || !last_host);
	assign core_req_ready = core_req_valid && (!host_req_valid || last_host);

	assign mem_en    = core_req_ready || host_req_ready;
	assign mem_we    = host_req_ready ? host_req_we : (core_req_ready && core_req_we);
	assign mem_addr  = host_req_ready ? host_req_addr : core_req_addr;
	assign mem_wdata = host_req_ready ? host_req_wdata : core_req_wdata;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			last_host        <= 1'b0;
			core_rdata_valid <= 1'b0;
			host_rdata_valid <= 1'b0;
		end
		else
		begin
			if (mem_en)
				last_host <= host_req_ready;
			// Owner of the read sees the pulse
			core_rdata_valid <= core_req_ready && !core_req_we;
			host_rdata_valid <= host_req_ready && !host_req_we;
		end
	end

	// A losing host request waits unchanged for its grant
	host_hold: assert property (@(posedge clk) disable iff (rst)
		host_req_valid && !host_req_ready |=>
			host_req_valid && $stable(host_req_addr) && $stable(host_req_we)
			&& $stable(host_req_wdata))
		else $error("mem_arbiter: host request dropped or changed before acceptance");

endmodule

// ==== hw/unified_mem.sv ====
module unified_mem import mips_pkg::*;
(
	input  logic  clk,
	input  logic  en,
	input  logic  we,
	input  addr_t addr,
	input  word_t wdata,
	output word_t rdata
);

	word_t mem [MEM_WORDS];

	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (we)
				mem[addr] <= wdata;
			rdata <= mem[addr];  // Old word on a write
		end
	end

endmodule

// ==== hw/mips_top.sv ====
module mips_top import mips_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  run,
	output logic  halted,
	// Host port
	input  logic  host_req_valid,
	output logic  host_req_ready,
	input  logic  host_req_we,
	input  addr_t host_req_addr,
	input  word_t host_req_wdata,
	output word_t host_rdata,
	output logic  host_rdata_valid
);

	logic       core_req_valid;
	logic       core_req_ready;
	logic       core_req_we;
	addr_t      core_req_addr;
	word_t      core_req_wdata;
	logic       core_rdata_valid;

	logic       mem_en;
	logic       mem_we;
	addr_t      mem_addr;
	word_t      mem_wdata;

	logic [5:0] opcode;
	logic [5:0] funct;
	alu_op_t    alu_op;
	logic       alu_src;
	logic       reg_dst;
	logic       shamt_sel;
	logic       mem_read;
	logic       mem_write;
	logic       branch;
	logic       mem_to_reg;
	logic       reg_write;
	logic       is_jump;
	logic       is_jr;
	logic       is_halt;

	reg_idx_t   ra1;
	reg_idx_t   ra2;
	reg_idx_t   wa;
	word_t      rd1;
	word_t      rd2;
	word_t      wd;
	logic       we;

	word_t      alu_a;
	word_t      alu_b;
	word_t      alu_y;
	logic [4:0] alu_shamt;
	logic       alu_zero;

	//////////////////////////////
	// Core

	core_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.run         (run),
		.halted      (halted),
		.req_valid   (core_req_valid),
		.req_ready   (core_req_ready),
		.req_we      (core_req_we),
		.req_addr    (core_req_addr),
		.req_wdata   (core_req_wdata),
		.rdata       (host_rdata),  // Shared read bus
		.rdata_valid (core_rdata_valid),
		.opcode      (opcode),
		.funct       (funct),
		.alu_op      (alu_op),
		.alu_src     (alu_src),
		.reg_dst     (reg_dst),
		.shamt_sel   (shamt_sel),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.branch      (branch),
		.mem_to_reg  (mem_to_reg),
		.reg_write   (reg_write),
		.is_jump     (is_jump),
		.is_jr       (is_jr),
		.is_halt     (is_halt),
		.ra1         (ra1),
		.ra2         (ra2),
		.rd1         (rd1),
		.rd2         (rd2),
		.we          (we),
		.wa          (wa),
		.wd          (wd),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_shamt   (alu_shamt),
		.alu_y       (alu_y),
		.alu_zero    (alu_zero)
	);

	decoder u_dec (
		.opcode     (opcode),
		.funct      (funct),
		.alu_op     (alu_op),
		.alu_src    (alu_src),
		.reg_dst    (reg_dst),
		.shamt_sel  (shamt_sel),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.branch     (branch),
		.mem_to_reg (mem_to_reg),
		.reg_write  (reg_write),
		.is_jump    (is_jump),
		.is_jr      (is_jr),
		.is_halt    (is_halt)
	);

	alu u_alu (
		.a     (alu_a),
		.b     (alu_b),
		.shamt (alu_shamt),
		.op    (alu_op),
		.y     (alu_y),
		.zero  (alu_zero)
	);

	reg_file u_rf (
		.clk (clk),
		.rst (rst),
		.ra1 (ra1),
		.ra2 (ra2),
		.we  (we),
		.wa  (wa),
		.wd  (wd),
		.rd1 (rd1),
		.rd2 (rd2)
	);

	//////////////////////////////
	// Shared memory

	mem_arbiter u_arb (
		.clk              (clk),
		.rst              (rst),
		.core_req_valid   (core_req_valid),
		.core_req_ready   (core_req_ready),
		.core_req_we      (core_req_we),
		.core_req_addr    (core_req_addr),
		.core_req_wdata   (core_req_wdata),
		.core_rdata_valid (core_rdata_valid),
		.host_req_valid   (host_req_valid),
		.host_req_ready   (host_req_ready),
		.host_req_we      (host_req_we),
		.host_req_addr    (host_req_addr),
		.host_req_wdata   (host_req_wdata),
		.host_rdata_valid (host_rdata_valid),
		.mem_en           (mem_en),
		.mem_we           (mem_we),
		.mem_addr         (mem_addr),
		.mem_wdata        (mem_wdata)
	);

	unified_mem u_mem (
		.clk   (clk),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (host_rdata)
	);

endmodule

// ==== dv/mips_tb.sv ====
module mips_tb import mips_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int    MAX_RECS       = 128;
	localparam int    CYCLES_PER_REC = 200;
	localparam addr_t SCRATCH_BASE   = 10'h300;  // Host-only area that no program touches

	logic        clk;
	logic        rst;
	logic        run;
	logic        halted;
	logic        host_req_valid;
	logic        host_req_ready;
	logic        host_req_we;
	addr_t       host_req_addr;
	word_t       host_req_wdata;
	word_t       host_rdata;
	logic        host_rdata_valid;

	logic [47:0] recs [MAX_RECS];  // tag, address, data
	int          n_recs;
	int          limit_cycles;
	int          errors;
	int          checks;
	logic [31:0] rnd_state;

	mips_top u_dut (
		.clk              (clk),
		.rst              (rst),
		.run              (run),
		.halted           (halted),
		.host_req_valid   (host_req_valid),
		.host_req_ready   (host_req_ready),
		.host_req_we      (host_req_we),
		.host_req_addr    (host_req_addr),
		.host_req_wdata   (host_req_wdata),
		.host_rdata       (host_rdata),
		.host_rdata_valid (host_rdata_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function logic [31:0] next_rand();
		rnd_state = rnd_state ^ (rnd_state << 13);
		rnd_state = rnd_state ^ (rnd_state >> 17);
		rnd_state = rnd_state ^ (rnd_state << 5);
		return rnd_state;
	endfunction

	// One clock and a step past the edge
	task wait_cycle();
		@(posedge clk);
		#1;
	endtask

	task apply_reset();
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	task check_word(input addr_t addr, input word_t exp, input word_t got);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERR %0t: word at %03h expected %08h got %08h", $time, addr, exp, got);
		end
	endtask

	//////////////////////////////
	// Host port access

	task host_access(input logic wr, input addr_t addr, input word_t data, output word_t rd);
		logic accepted;
		int   waits;
		host_req_valid = 1'b1;
		host_req_we    = wr;
		host_req_addr  = addr;
		host_req_wdata = data;
		accepted       = 1'b0;
		while (!accepted)
		begin
			#2 accepted = host_req_ready;  // Sampled mid cycle once settled
			wait_cycle();
		end
		host_req_valid = 1'b0;
		host_req_we    = 1'b0;
		rd             = '0;
		if (!wr)
		begin
			waits = 0;
			while (!host_rdata_valid && waits < 4)
			begin
				wait_cycle();
				waits++;
			end
			assert (host_rdata_valid)
			else
			begin
				errors++;
				$display("Host read of address %03h never got its read data", addr);
			end
			rd = host_rdata;
		end
	endtask

	// Start the core and poke scratch words until it halts
	task run_program();
		int    gap;
		addr_t slot;
		word_t data;
		word_t rd;
		apply_reset();
		assert (!halted)
		else
		begin
			errors++;
			$display("Core still reports halted after reset");
		end
		run = 1'b1;
		wait_cycle();
		run = 1'b0;
		while (!halted)
		begin
			gap = int'(next_rand() % 5);
			repeat (gap) wait_cycle();
			if (!halted)
			begin
				slot = SCRATCH_BASE + addr_t'(next_rand() % 16);
				data = next_rand();
				host_access(1'b1, slot, data, rd);
				host_access(1'b0, slot, '0, rd);
				check_word(slot, data, rd);
			end
		end
	endtask

	//////////////////////////////
	// Main sequence

	initial
	begin
		word_t rd;
		rst            = 1'b1;
		run            = 1'b0;
		host_req_valid = 1'b0;
		host_req_we    = 1'b0;
		host_req_addr  = '0;
		host_req_wdata = '0;
		errors         = 0;
		checks         = 0;
		limit_cycles   = 0;
		rnd_state      = 32'h8ed6_8849;

		$readmemh("dv/prog_vectors.txt", recs);
		n_recs = 0;
		while (n_recs < MAX_RECS && !$isunknown(recs[n_recs]) && recs[n_recs][47:44] != 4'hf)
			n_recs++;
		limit_cycles = (n_recs + 1) * CYCLES_PER_REC;
		assert (n_recs > 0)
		else
		begin
			errors++;
			$display("Vectors file is missing or holds no records");
		end

		apply_reset();
		for (int i = 0; i < n_recs; i++)
		begin
			case (recs[i][47:44])
				4'h1: host_access(1'b1, recs[i][41:32], recs[i][31:0], rd);  // Load word
				4'h2: run_program();
				4'h3:
				begin
					host_access(1'b0, recs[i][41:32], '0, rd);
					check_word(recs[i][41:32], recs[i][31:0], rd);
				end
				default:
				begin
					errors++;
					$display("Vectors record %0d has an unknown tag %h", i, recs[i][47:44]);
				end
			endcase
		end

		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Hang guard scaled by the number of records
	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, the core never halted or the host port stalled",
			limit_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== dv/prog_vectors.txt ====
// Columns: tag (1 hex) word address (3 hex) data (8 hex)
// Tags: 1 load word via host, 2 run core until halted, 3 expect word, f end of records
// Program 1, R-type and immediates, results at 0x100
10002001fffb // addi $1,$0,-5
100120020003 // addi $2,$0,3
100200411804 // sllv $3,$1,$2
10030022202a // slt  $4,$1,$2
100400012843 // sra  $5,$1,1
100500413023 // subu $6,$2,$1
100600403827 // nor  $7,$2,$0
100700226826 // xor  $13,$1,$2
10083c081234 // lui  $8,0x1234
100935088765 // ori  $8,$8,0x8765
100a3029ff00 // andi $9,$1,0xff00
100b284affff // slti $10,$2,-1
100c382b8000 // xori $11,$1,0x8000
100dac030100
100eac040101
100fac050102
1010ac060103
1011ac070104
1012ac0d0105
1013ac080106
1014ac090107
1015ac0a0108
1016ac0b0109
1017fc000000 // halt
200000000000
3100ffffffd8
310100000001
3102fffffffd
310300000008
3104fffffffc
3105fffffff8
310612348765
31070000ff00
310800000000
3109ffff7ffb
// Program 2, loads, stores, $zero and control flow
1110cafef00d // source word for lw
111311111111 // must survive the skipped stores
10008c010110 // lw   $1,0x110($0)
1001ac010111 // sw   $1,0x111($0)
100220000007 // addi $0,$0,7
1003ac000112 // sw   $0,0x112($0)
100410210001 // beq  $1,$1,+1
1005ac010113
100614200001 // bne  $1,$0,+1
1007ac010113
10080800000a // j    10
1009ac010113
100a2002000d // addi $2,$0,13
100b00400008 // jr   $2
100cac010113
100d14000001 // bne  $0,$0,+1 not taken
100eac020114 // sw   $2,0x114($0)
100ffc000000 // halt
200000000000
3111cafef00d
311200000000
311311111111
31140000000d
f00000000000

// ==== filelist.f ====
hw/mips_pkg.sv
hw/decoder.sv
hw/alu.sv
hw/reg_file.sv
hw/core_ctrl.sv
hw/mem_arbiter.sv
hw/unified_mem.sv
hw/mips_top.sv
dv/mips_tb.sv
